// File: filelist.f
+incdir+source
source/vga_timing_pkg.sv
source/vga_bus_pkg.sv
source/vga_reg_slave.sv
source/vga_timing_gen.sv
source/vga_line_fetch.sv
source/vga_line_buffer.sv
source/vga_scanout.sv
source/vga_ctrl.sv
tb/fb_mem_model.sv
tb/tb_vga_ctrl.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_vga_ctrl"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_vga_ctrl
	./obj_dir/Vtb_vga_ctrl | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: tb/tb_vga_ctrl.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module tb_vga_ctrl;
    import vga_bus_pkg::*;
    import vga_timing_pkg::*;

    localparam int          CLK_NS       = 4;
    localparam int          SEED         = 27;
    localparam int          HS_LIMIT     = 64;
    localparam int          MAX_ERRORS   = 20;
    localparam logic [31:0] HASH_MUL     = 32'h9E37_79B1;
    localparam logic [31:0] FB_BASE      = 32'h0010_0000;
    localparam int          FRAME_CYCLES = 2 * `VGA_H_TOTAL * `VGA_V_TOTAL;
    // three frames plus the reset and register phase
    localparam int          WATCHDOG_NS  = CLK_NS * (3 * FRAME_CYCLES + 1000);

    logic        clock = 1'b0;
    logic        rst;
    logic        m_arready;
    logic        m_arvalid;
    logic [31:0] m_araddr;
    logic [7:0]  m_arlen;
    logic [2:0]  m_arsize;
    axi_burst_e  m_arburst;
    logic        m_rvalid;
    logic        m_rlast;
    logic [63:0] m_rdata;
    axi_resp_e   m_rresp;
    logic        m_rready;
    logic        s_awvalid;
    logic [31:0] s_awaddr;
    logic [3:0]  s_awid;
    logic        s_awready;
    logic        s_wvalid;
    logic [63:0] s_wdata;
    logic        s_wlast;
    logic        s_wready;
    logic        s_bvalid;
    logic [3:0]  s_bid;
    axi_resp_e   s_bresp;
    logic        s_bready;
    logic        s_arvalid;
    logic [31:0] s_araddr;
    logic [3:0]  s_arid;
    logic        s_arready;
    logic        s_rvalid;
    logic [63:0] s_rdata;
    logic        s_rlast;
    logic [3:0]  s_rid;
    axi_resp_e   s_rresp;
    logic        s_rready;
    logic        hsync;
    logic        vsync;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;

    int          errors = 0;
    logic [31:0] base_val = '0;
    int          ar_line = 0;
    int          ar_burst = 0;
    bit          wrap_seen = 1'b0;
    bit          prev_h = 1'b0;
    bit          prev_v = 1'b0;
    bit          h_seen = 1'b0;
    int          hcnt = 0;
    int          hlow = 0;
    int          v_rises = 0;
    int          v_hrises = 0;
    int          vlow_lines = 0;
    int          vline = 0;
    int          pixels_checked = 0;

    vga_ctrl DUT (.*);

    fb_mem_model #(.HASH_MUL(HASH_MUL)) u_mem (
        .clock   (clock),
        .rst     (rst),
        .arvalid (m_arvalid),
        .araddr  (m_araddr),
        .arlen   (m_arlen),
        .arready (m_arready),
        .rvalid  (m_rvalid),
        .rlast   (m_rlast),
        .rdata   (m_rdata),
        .rresp   (m_rresp),
        .rready  (m_rready)
    );

    always #(CLK_NS / 2) clock = ~clock;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%0t %s", $time, what);
    endtask

    task automatic end_run();
        $display("run complete: %0d errors, %0d active pixels compared", errors, pixels_checked);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    function automatic logic [7:0] byte_hash(input logic [31:0] a);
        logic [31:0] m;
        m = a * HASH_MUL;
        return m[31:24];
    endfunction

    // word of pixel pair in memory, even pixel in bytes 0..2, odd in 4..6, red in the top byte
    function automatic rgb_t expected_pixel(input int line, input int px);
        logic [31:0] a;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        a  = base_val + line * `VGA_LINE_BYTES + (px / 2) * 8 + (px % 2) * 4;
        b0 = byte_hash(a);
        b1 = byte_hash(a + 1);
        b2 = byte_hash(a + 2);
        return {b2[7:4], b1[7:4], b0[7:4]};
    endfunction

    task automatic write_reg(input logic [31:0] addr, input logic [63:0] data,
                             input logic [3:0] id);
        int n;
        @(posedge clock);
        #1;
        s_awvalid = 1'b1;
        s_awaddr  = addr;
        s_awid    = id;
        for (n = 0; n < HS_LIMIT; n++) begin
            @(posedge clock);
            if (s_awready) break;
        end
        if (n == HS_LIMIT) report_failure("write address was never accepted");
        #1;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b1;
        s_wdata   = data;
        s_wlast   = 1'b1;
        for (n = 0; n < HS_LIMIT; n++) begin
            @(posedge clock);
            if (s_wready) break;
        end
        if (n == HS_LIMIT) report_failure("write data was never accepted");
        #1;
        s_wvalid = 1'b0;
        s_wlast  = 1'b0;
        s_bready = 1'b1;
        for (n = 0; n < HS_LIMIT; n++) begin
            @(posedge clock);
            if (s_bvalid) break;
        end
        if (n == HS_LIMIT) report_failure("no write response arrived");
        check("s_bid", s_bid, id);
        check("s_bresp", s_bresp, OKAY);
        #1;
        s_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [3:0] id,
                            output logic [63:0] data);
        int n;
        @(posedge clock);
        #1;
        s_arvalid = 1'b1;
        s_araddr  = addr;
        s_arid    = id;
        for (n = 0; n < HS_LIMIT; n++) begin
            @(posedge clock);
            if (s_arready) break;
        end
        if (n == HS_LIMIT) report_failure("read address was never accepted");
        #1;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        for (n = 0; n < HS_LIMIT; n++) begin
            @(posedge clock);
            if (s_rvalid) break;
        end
        if (n == HS_LIMIT) report_failure("no read data arrived");
        check("s_rid", s_rid, id);
        check("s_rlast", s_rlast, 1'b1);
        check("s_rresp", s_rresp, OKAY);
        data = s_rdata;
        #1;
        s_rready = 1'b0;
    endtask

    // every AR request follows line and burst order
    always @(posedge clock) begin
        if (!rst && m_arvalid && m_arready) begin
            check("m_araddr", m_araddr,
                  base_val + ar_line * `VGA_LINE_BYTES + ar_burst * `VGA_BURST_BYTES);
            check("m_arlen", m_arlen, `VGA_BURST_BEATS - 1);
            check("m_arsize", m_arsize, 3'd3);
            check("m_arburst", m_arburst, INCR);
            ar_burst++;
            if (ar_burst == `VGA_BURSTS_PER_LINE) begin
                ar_burst = 0;
                ar_line++;
                if (ar_line == `VGA_ACTIVE_LINES) begin
                    ar_line   = 0;
                    wrap_seen = 1'b1;
                end
            end
        end
    end

    // sync periods, and pixels located from the sync rising edges
    always @(posedge clock) begin : compare_raster
        int   t;
        rgb_t exp_pix;
        if (rst) begin
            prev_h = 1'b0;
            prev_v = 1'b0;
        end else begin
            if (vsync && !prev_v) begin
                if (v_rises > 0) begin
                    check("vsync period in lines", v_hrises, `VGA_V_TOTAL);
                    check("vsync low lines", vlow_lines, `VGA_V_SYNC_END);
                end
                v_rises++;
                v_hrises   = 0;
                vlow_lines = 0;
                vline      = `VGA_V_SYNC_END;
            end
            if (hsync && !prev_h) begin
                if (h_seen) begin
                    check("hsync period", hcnt, 2 * `VGA_H_TOTAL);
                    check("hsync low cycles", hlow, 2 * `VGA_H_SYNC_END);
                end
                h_seen = 1'b1;
                hcnt   = 0;
                hlow   = 0;
                v_hrises++;
                if (!vsync) vlow_lines++;
                vline++;
            end
            // odd count is the second cycle of a tick
            if (v_rises == 1 && h_seen && hcnt % 2 == 1) begin
                t       = `VGA_H_SYNC_END + 1 + hcnt / 2;
                exp_pix = '0;
                if (vline > `VGA_V_ACT_START && vline <= `VGA_V_ACT_END &&
                    t > `VGA_H_ACT_START && t <= `VGA_H_ACT_END) begin
                    exp_pix = expected_pixel(vline - `VGA_V_ACT_START - 1,
                                             t - `VGA_H_ACT_START - 1);
                    pixels_checked++;
                end
                check("vga_rgb", {vga_r, vga_g, vga_b}, exp_pix);
            end
            if (!hsync) hlow++;
            hcnt++;
            prev_h = hsync;
            prev_v = vsync;
        end
    end

    initial begin
        logic [63:0] rd;
        void'($urandom(SEED));
        rst       = 1'b1;
        s_awvalid = 1'b0;
        s_awaddr  = '0;
        s_awid    = '0;
        s_wvalid  = 1'b0;
        s_wdata   = '0;
        s_wlast   = 1'b0;
        s_bready  = 1'b0;
        s_arvalid = 1'b0;
        s_araddr  = '0;
        s_arid    = '0;
        s_rready  = 1'b0;
        repeat (16) @(posedge clock);
        #1;
        rst = 1'b0;
        // base is still zero so nothing may start
        repeat (32) begin
            @(posedge clock);
            check("m_arvalid", m_arvalid, 1'b0);
            check("s_rvalid", s_rvalid, 1'b0);
            check("s_bvalid", s_bvalid, 1'b0);
            check("s_awready", s_awready, 1'b1);
            check("s_arready", s_arready, 1'b1);
            check("hsync", hsync, 1'b0);
            check("vsync", vsync, 1'b0);
            check("vga_rgb", {vga_r, vga_g, vga_b}, 12'h000);
        end
        base_val = FB_BASE;
        write_reg(`VGA_BASE_REG_ADDR, {FB_BASE, 32'h0}, 4'h5);
        read_reg(`VGA_BASE_REG_ADDR, 4'h9, rd);
        check("s_rdata[63:32] at base address", rd[63:32], FB_BASE);
        read_reg(32'h0, 4'h3, rd);
        check("s_rdata at address 0", rd, 64'h0);
        wait (v_rises == 2);
        check("active pixels in frame", pixels_checked,
              `VGA_ACTIVE_LINES * 2 * `VGA_LINE_WORDS);
        if (!wrap_seen) report_failure("fetch line number never wrapped to line 0");
        end_run();
    end

    initial begin
        wait (errors >= MAX_ERRORS);
        $display("%0t too many errors, stopping early", $time);
        end_run();
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before a full frame was checked");
        end_run();
    end

endmodule

// File: tb/fb_mem_model.sv
`timescale 1ns/1ps

module fb_mem_model #(
    parameter logic [31:0] HASH_MUL = 32'h9E37_79B1
) (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   arvalid,
    input  logic [31:0]            araddr,
    input  logic [7:0]             arlen,
    output logic                   arready,
    output logic                   rvalid,
    output logic                   rlast,
    output logic [63:0]            rdata,
    output vga_bus_pkg::axi_resp_e rresp,
    input  logic                   rready
);
    import vga_bus_pkg::*;

    logic        busy = 1'b0;
    logic        ar_rdy = 1'b0;
    logic        r_vld = 1'b0;
    logic [31:0] addr_q = '0;
    logic [7:0]  left_q = '0;
    int          stall = 0;

    // byte k of a word is a hash of its own byte address
    function automatic logic [63:0] word_at(input logic [31:0] a);
        logic [63:0] w;
        logic [31:0] m;
        for (int k = 0; k < 8; k++) begin
            m = (a + k) * HASH_MUL;
            w[8*k +: 8] = m[31:24];
        end
        return w;
    endfunction

    assign arready = ar_rdy;
    assign rvalid  = r_vld;
    assign rlast   = (left_q == 8'd0);
    assign rdata   = word_at(addr_q);
    assign rresp   = OKAY;

    // one burst in flight, random gaps before the address and each beat
    always @(posedge clock) begin : step
        logic        in_rst;
        logic        ar_hs;
        logic        r_hs;
        logic [31:0] ar_addr;
        logic [7:0]  ar_len;
        in_rst  = rst;
        ar_hs   = arvalid && ar_rdy;
        r_hs    = r_vld && rready;
        ar_addr = araddr;
        ar_len  = arlen;
        #1;
        if (in_rst) begin
            busy   = 1'b0;
            ar_rdy = 1'b0;
            r_vld  = 1'b0;
            stall  = 0;
        end else if (!busy) begin
            if (ar_hs) begin
                ar_rdy = 1'b0;
                busy   = 1'b1;
                addr_q = ar_addr;
                left_q = ar_len;
                stall  = $urandom_range(3, 0);
            end else if (stall > 0) begin
                stall--;
            end else begin
                ar_rdy = 1'b1;
            end
        end else if (r_hs) begin
            r_vld = 1'b0;
            if (left_q == 8'd0) begin
                busy = 1'b0;
            end else begin
                addr_q = addr_q + 32'd8;
                left_q = left_q - 8'd1;
            end
            stall = $urandom_range(3, 0);
        end else if (!r_vld) begin
            if (stall > 0) begin
                stall--;
            end else begin
                r_vld = 1'b1;
            end
        end
    end

endmodule

// File: source/vga_ctrl.sv
`timescale 1ns/1ps

module vga_ctrl (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    m_arready,
    output logic                    m_arvalid,
    output logic [31:0]             m_araddr,
    output logic [7:0]              m_arlen,
    output logic [2:0]              m_arsize,
    output vga_bus_pkg::axi_burst_e m_arburst,
    input  logic                    m_rvalid,
    input  logic                    m_rlast,
    input  logic [63:0]             m_rdata,
    input  vga_bus_pkg::axi_resp_e  m_rresp,
    output logic                    m_rready,
    input  logic                    s_awvalid,
    input  logic [31:0]             s_awaddr,
    input  logic [3:0]              s_awid,
    output logic                    s_awready,
    input  logic                    s_wvalid,
    input  logic [63:0]             s_wdata,
    input  logic                    s_wlast,
    output logic                    s_wready,
    output logic                    s_bvalid,
    output logic [3:0]              s_bid,
    output vga_bus_pkg::axi_resp_e  s_bresp,
    input  logic                    s_bready,
    input  logic                    s_arvalid,
    input  logic [31:0]             s_araddr,
    input  logic [3:0]              s_arid,
    output logic                    s_arready,
    output logic                    s_rvalid,
    output logic [63:0]             s_rdata,
    output logic                    s_rlast,
    output logic [3:0]              s_rid,
    output vga_bus_pkg::axi_resp_e  s_rresp,
    input  logic                    s_rready,
    output logic                    hsync,
    output logic                    vsync,
    output logic [3:0]              vga_r,
    output logic [3:0]              vga_g,
    output logic [3:0]              vga_b
);
    import vga_timing_pkg::*;

    logic [31:0] base;
    logic        run;
    logic        pixel_tick;
    logic        active;
    logic        line_end;
    logic        line_done;
    hcount_t     h_next;
    vcount_t     v_next;
    logic        wr_en;
    logic        wr_bank;
    line_word_t  wr_word;
    logic [23:0] wr_data;
    logic        rd_en;
    logic        rd_bank;
    line_word_t  rd_word;
    logic [23:0] rd_data;
    logic [1:0]  ready_lines;

    vga_reg_slave u_reg_slave (
        .clock   (clock),
        .rst     (rst),
        .awvalid (s_awvalid),
        .awaddr  (s_awaddr),
        .awid    (s_awid),
        .awready (s_awready),
        .wvalid  (s_wvalid),
        .wdata   (s_wdata),
        .wlast   (s_wlast),
        .wready  (s_wready),
        .bvalid  (s_bvalid),
        .bid     (s_bid),
        .bresp   (s_bresp),
        .bready  (s_bready),
        .arvalid (s_arvalid),
        .araddr  (s_araddr),
        .arid    (s_arid),
        .arready (s_arready),
        .rvalid  (s_rvalid),
        .rdata   (s_rdata),
        .rlast   (s_rlast),
        .rid     (s_rid),
        .rresp   (s_rresp),
        .rready  (s_rready),
        .base    (base)
    );

    vga_timing_gen u_timing_gen (
        .clock      (clock),
        .rst        (rst),
        .run        (run),
        .pixel_tick (pixel_tick),
        .hsync      (hsync),
        .vsync      (vsync),
        .active     (active),
        .line_end   (line_end),
        .h_next     (h_next),
        .v_next     (v_next)
    );

    vga_line_fetch u_line_fetch (
        .clock       (clock),
        .rst         (rst),
        .base        (base),
        .line_done   (line_done),
        .run         (run),
        .arready     (m_arready),
        .arvalid     (m_arvalid),
        .araddr      (m_araddr),
        .arlen       (m_arlen),
        .arsize      (m_arsize),
        .arburst     (m_arburst),
        .rvalid      (m_rvalid),
        .rlast       (m_rlast),
        .rdata       (m_rdata),
        .rresp       (m_rresp),
        .rready      (m_rready),
        .wr_en       (wr_en),
        .wr_bank     (wr_bank),
        .wr_word     (wr_word),
        .wr_data     (wr_data),
        .ready_lines (ready_lines)
    );

    vga_line_buffer u_line_buffer (
        .clock       (clock),
        .wr_en       (wr_en),
        .wr_bank     (wr_bank),
        .wr_word     (wr_word),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_bank     (rd_bank),
        .rd_word     (rd_word),
        .ready_lines (ready_lines),
        .rd_data     (rd_data)
    );

    vga_scanout u_scanout (
        .clock      (clock),
        .pixel_tick (pixel_tick),
        .active     (active),
        .line_end   (line_end),
        .h_next     (h_next),
        .v_next     (v_next),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .rd_bank    (rd_bank),
        .line_done  (line_done),
        .rd_word    (rd_word),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b)
    );

endmodule

// File: source/vga_scanout.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_scanout (
    input  logic                       clock,
    input  logic                       pixel_tick,
    input  logic                       active,
    input  logic                       line_end,
    input  vga_timing_pkg::hcount_t    h_next,
    input  vga_timing_pkg::vcount_t    v_next,
    input  logic [23:0]                rd_data,
    output logic                       rd_en,
    output logic                       rd_bank,
    output logic                       line_done,
    output vga_timing_pkg::line_word_t rd_word,
    output logic [3:0]                 vga_r,
    output logic [3:0]                 vga_g,
    output logic [3:0]                 vga_b
);
    import vga_timing_pkg::*;

    hcount_t px;
    vcount_t ln;
    logic    next_active;
    logic    half_q;
    rgb_t    pix;

    assign px          = h_next - hcount_t'(`VGA_H_ACT_START + 1);
    assign ln          = v_next - vcount_t'(`VGA_V_ACT_START + 1);
    assign next_active = (h_next > `VGA_H_ACT_START) && (h_next <= `VGA_H_ACT_END) &&
                         (v_next > `VGA_V_ACT_START) && (v_next <= `VGA_V_ACT_END);

    // fetch one tick ahead so data lands as the pixel starts
    assign rd_en   = pixel_tick && next_active;
    assign rd_word = px[9:1];
    assign rd_bank = ln[0];

    always_ff @(posedge clock) begin
        if (rd_en) half_q <= px[0];
    end

    assign pix       = half_q ? rd_data[23:12] : rd_data[11:0];
    assign vga_r     = active ? pix.r : 4'd0;
    assign vga_g     = active ? pix.g : 4'd0;
    assign vga_b     = active ? pix.b : 4'd0;
    assign line_done = line_end;

endmodule

// File: source/vga_line_buffer.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_line_buffer (
    input  logic                       clock,
    input  logic                       wr_en,
    input  logic                       wr_bank,
    input  vga_timing_pkg::line_word_t wr_word,
    input  logic [23:0]                wr_data,
    input  logic                       rd_en,
    input  logic                       rd_bank,
    input  vga_timing_pkg::line_word_t rd_word,
    input  logic [1:0]                 ready_lines,
    output logic [23:0]                rd_data
);
    import vga_timing_pkg::*;

    logic rd_sel;

    for (genvar b = 0; b < 2; b++) begin : gen_bank
        logic [23:0] mem [0:`VGA_LINE_WORDS-1];
        logic [23:0] q;
        logic        own_w;
        line_word_t  addr;

        // writer owns the bank being filled until both lines are ready
        assign own_w = (wr_bank == 1'(b)) && (ready_lines < 2'd2);
        assign addr  = own_w ? wr_word : rd_word;

        always_ff @(posedge clock) begin
            if (own_w) begin
                if (wr_en) mem[addr] <= wr_data;
            end else if (rd_en && rd_bank == 1'(b)) begin
                q <= mem[addr];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_en) rd_sel <= rd_bank;
    end

    assign rd_data = rd_sel ? gen_bank[1].q : gen_bank[0].q;

    // a write into a bank held by the reader is lost
    assert property (@(posedge clock) wr_en |-> ready_lines < 2'd2);

endmodule

// File: source/vga_line_fetch.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_line_fetch (
    input  logic                       clock,
    input  logic                       rst,
    input  logic [31:0]                base,
    input  logic                       line_done,
    output logic                       run,
    input  logic                       arready,
    output logic                       arvalid,
    output logic [31:0]                araddr,
    output logic [7:0]                 arlen,
    output logic [2:0]                 arsize,
    output vga_bus_pkg::axi_burst_e    arburst,
    input  logic                       rvalid,
    input  logic                       rlast,
    input  logic [63:0]                rdata,
    input  vga_bus_pkg::axi_resp_e     rresp,
    output logic                       rready,
    output logic                       wr_en,
    output logic                       wr_bank,
    output vga_timing_pkg::line_word_t wr_word,
    output logic [23:0]                wr_data,
    output logic [1:0]                 ready_lines
);
    import vga_bus_pkg::*;
    import vga_timing_pkg::*;

    fetch_state_e state;
    line_idx_t    line_q;
    logic [4:0]   burst_q;
    line_word_t   word_q;
    logic         enabled;
    logic         beat;
    logic         line_last;

    assign enabled   = (base != '0);
    assign beat      = rvalid && rready;
    assign line_last = beat && rlast && (burst_q == `VGA_BURSTS_PER_LINE - 1);

    assign arvalid = (state == F_ADDR);
    assign rready  = (state == F_DATA);
    assign araddr  = base + 32'(line_q) * `VGA_LINE_BYTES + 32'(burst_q) * `VGA_BURST_BYTES;
    assign arlen   = 8'(`VGA_BURST_BEATS - 1);
    assign arsize  = 3'd3;
    assign arburst = INCR;

    // error beats keep their slot but are not written
    assign wr_en   = beat && (rresp == OKAY || rresp == EXOKAY);
    assign wr_bank = line_q[0];
    assign wr_word = word_q;
    assign wr_data = {rdata[55:52], rdata[47:44], rdata[39:36],
                      rdata[23:20], rdata[15:12], rdata[7:4]};

    always_ff @(posedge clock) begin
        if (rst) begin
            state       <= F_IDLE;
            line_q      <= '0;
            burst_q     <= '0;
            word_q      <= '0;
            ready_lines <= '0;
            run         <= 1'b0;
        end else begin
            case (state)
                F_IDLE: if (enabled && ready_lines < 2'd2) state <= F_ADDR;
                F_ADDR: if (arready) state <= F_DATA;
                F_DATA: begin
                    if (beat && rlast) state <= line_last ? F_IDLE : F_ADDR;
                end
                default: state <= F_IDLE;
            endcase
            if (beat) begin
                word_q <= line_last ? '0 : word_q + 9'd1;
                if (rlast) burst_q <= line_last ? '0 : burst_q + 5'd1;
            end
            if (line_last) begin
                line_q <= (line_q == `VGA_ACTIVE_LINES - 1) ? '0 : line_q + 10'd1;
            end
            ready_lines <= ready_lines + {1'b0, line_last} - {1'b0, line_done};
            // raster starts once both banks hold a line
            if (enabled && ready_lines == 2'd2) run <= 1'b1;
        end
    end

    assert property (@(posedge clock) disable iff (rst) ready_lines != 2'd3);

endmodule

// File: source/vga_timing_gen.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_timing_gen (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    run,
    output logic                    pixel_tick,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    active,
    output logic                    line_end,
    output vga_timing_pkg::hcount_t h_next,
    output vga_timing_pkg::vcount_t v_next
);
    import vga_timing_pkg::*;

    logic    tick_q;
    hcount_t h_cur;
    vcount_t v_cur;
    logic    v_active;

    // pixel clock enable at half the clock rate
    always_ff @(posedge clock) begin
        if (rst) begin
            tick_q <= 1'b0;
        end else begin
            tick_q <= ~tick_q;
        end
    end

    assign pixel_tick = tick_q;

    // next-position counters, current position trails by one tick
    always_ff @(posedge clock) begin
        if (rst || !run) begin
            h_next <= '0;
            v_next <= '0;
            h_cur  <= '0;
            v_cur  <= '0;
        end else if (pixel_tick) begin
            h_cur <= h_next;
            v_cur <= v_next;
            if (h_next == '0) begin
                h_next <= 11'd1;
                v_next <= 10'd1;
            end else if (h_next == `VGA_H_TOTAL) begin
                h_next <= 11'd1;
                v_next <= (v_next == `VGA_V_TOTAL) ? 10'd1 : v_next + 10'd1;
            end else begin
                h_next <= h_next + 11'd1;
            end
        end
    end

    assign hsync    = (h_cur > `VGA_H_SYNC_END);
    assign vsync    = (v_cur > `VGA_V_SYNC_END);
    assign v_active = (v_cur > `VGA_V_ACT_START) && (v_cur <= `VGA_V_ACT_END);
    assign active   = v_active && (h_cur > `VGA_H_ACT_START) && (h_cur <= `VGA_H_ACT_END);
    assign line_end = pixel_tick && v_active && (h_cur == `VGA_H_ACT_END);

endmodule

// File: source/vga_reg_slave.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_reg_slave (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   awvalid,
    input  logic [31:0]            awaddr,
    input  logic [3:0]             awid,
    output logic                   awready,
    input  logic                   wvalid,
    input  logic [63:0]            wdata,
    input  logic                   wlast,
    output logic                   wready,
    output logic                   bvalid,
    output logic [3:0]             bid,
    output vga_bus_pkg::axi_resp_e bresp,
    input  logic                   bready,
    input  logic                   arvalid,
    input  logic [31:0]            araddr,
    input  logic [3:0]             arid,
    output logic                   arready,
    output logic                   rvalid,
    output logic [63:0]            rdata,
    output logic                   rlast,
    output logic [3:0]             rid,
    output vga_bus_pkg::axi_resp_e rresp,
    input  logic                   rready,
    output logic [31:0]            base
);
    import vga_bus_pkg::*;

    wr_state_e   wr_state;
    rd_state_e   rd_state;
    logic [31:0] waddr_q;
    logic        w_beat;

    assign awready = (wr_state == W_IDLE);
    assign wready  = (wr_state == W_DATA);
    assign bvalid  = (wr_state == W_RESP);
    assign bresp   = OKAY;
    assign w_beat  = wvalid && wready;

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_state <= W_IDLE;
            waddr_q  <= '0;
            bid      <= '0;
            base     <= '0;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    if (awvalid) begin
                        wr_state <= W_DATA;
                        waddr_q  <= awaddr;
                        bid      <= awid;
                    end
                end
                W_DATA: if (w_beat && wlast) wr_state <= W_RESP;
                W_RESP: if (bready) wr_state <= W_IDLE;
                default: wr_state <= W_IDLE;
            endcase
            if (w_beat && waddr_q == `VGA_BASE_REG_ADDR) base <= wdata[63:32];
        end
    end

    // single-beat reads, data captured at the address handshake
    assign arready = (rd_state == R_IDLE);
    assign rvalid  = (rd_state == R_DATA);
    assign rlast   = rvalid;
    assign rresp   = OKAY;

    always_ff @(posedge clock) begin
        if (rst) begin
            rd_state <= R_IDLE;
            rdata    <= '0;
            rid      <= '0;
        end else begin
            case (rd_state)
                R_IDLE: begin
                    if (arvalid) begin
                        rd_state <= R_DATA;
                        rid      <= arid;
                        rdata    <= (araddr == `VGA_BASE_REG_ADDR) ? {base, 32'h0} : '0;
                    end
                end
                R_DATA: if (rready) rd_state <= R_IDLE;
                default: rd_state <= R_IDLE;
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (rst)
        $rose(bvalid) |-> $past(wvalid && wready && wlast));

endmodule

// File: source/vga_bus_pkg.sv
package vga_bus_pkg;

    typedef enum logic [1:0] {
        FIXED,
        INCR,
        WRAP
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY,
        EXOKAY,
        SLVERR,
        DECERR
    } axi_resp_e;

    typedef enum logic [1:0] {F_IDLE, F_ADDR, F_DATA} fetch_state_e;
    typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wr_state_e;
    typedef enum logic {R_IDLE, R_DATA} rd_state_e;

endpackage

// File: source/vga_timing_pkg.sv
package vga_timing_pkg;

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [8:0]  line_word_t;
    typedef logic [9:0]  line_idx_t;

    // 4 bits per colour
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage

// File: source/vga_config.svh
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// horizontal ticks, one-based
`define VGA_H_SYNC_END      120
`define VGA_H_ACT_START     184
`define VGA_H_ACT_END       984
`define VGA_H_TOTAL         1040

// vertical lines, one-based
`define VGA_V_SYNC_END      6
`define VGA_V_ACT_START     29
`define VGA_V_ACT_END       629
`define VGA_V_TOTAL         666

// two pixels per 64-bit word
`define VGA_ACTIVE_LINES    600
`define VGA_LINE_WORDS      400

`define VGA_BURST_BEATS     16
`define VGA_BURSTS_PER_LINE 25
`define VGA_LINE_BYTES      3200
`define VGA_BURST_BYTES     128

`define VGA_BASE_REG_ADDR   4

`endif
